//--- popPkg.sv
package popPkg;

	// floor of log2, -1 for n < 1
	function automatic int log2floor(input int n);
		int m;
		int p;
		m = -1;
		p = 1;
		while (p <= n) begin
			m++;
			p *= 2;
		end
		return m;
	endfunction

	localparam int wordWidth = 32;                     // operand width
	localparam int cntWidth  = log2floor(wordWidth) + 1; // holds 0..wordWidth
	localparam int accWidth  = 16;                     // run total width
	localparam int tagWidth  = 4;                      // beat and result tag

	// counter slice arrangement
	localparam int cntSpeed = 1;  // 1 tree, 0 linear chain

	// what the bit vector is built from
	typedef enum logic [1:0] {
		modePop = 2'd0,  // ones in opA
		modeHam = 2'd1,  // ones in opA ^ opB
		modeAnd = 2'd2   // ones in opA & opB
	} opMode_e;

	// count of one beat
	typedef logic [cntWidth-1:0] beatCount_t;

	// total over one run, saturating
	typedef logic [accWidth-1:0] accCount_t;

endpackage

//--- popIfs.sv
// selected bit vector, operandPrep to bitCounter
interface bitVecIf;

	import popPkg::*;

	logic                 valid;   // one-cycle strobe per beat
	logic [wordWidth-1:0] vector;  // bits to count
	logic                 last;    // closes the run
	logic [tagWidth-1:0]  tag;

	modport src (
		output valid, vector, last, tag
	);

	modport dst (
		input valid, vector, last, tag
	);

endinterface

// count of one beat, bitCounter to runAccumulator
interface countIf;

	import popPkg::*;

	logic                valid;  // one-cycle strobe per beat
	beatCount_t          count;  // ones in the beat
	logic                last;   // closes the run
	logic [tagWidth-1:0] tag;

	modport src (
		output valid, count, last, tag
	);

	modport dst (
		input valid, count, last, tag
	);

endinterface

//--- FullAdder.sv
module FullAdder (
	input  logic A,   // first addend
	input  logic B,   // second addend
	input  logic CI,  // third bit, carry in
	output logic S,   // weight one
	output logic CO   // weight two
);

	logic halfSum;  // A ^ B shared by sum and carry

	assign halfSum = A ^ B;
	assign S       = halfSum ^ CI;

	// carry when both addends set, or one of them plus CI
	assign CO = (A & B) | (halfSum & CI);

endmodule

//--- CntSlice.sv
module CntSlice #(
	parameter int depth = 4,  // bits going in
	parameter int speed = 1   // 0 chain, else tree
) (
	input  logic [depth-1:0]   A,   // bits of equal weight
	output logic               S,   // leftover sum bit, weight one
	output logic [depth/2-1:0] CO   // one carry per adder, weight two
);

	localparam int numFa    = depth / 2;                   // adders needed
	localparam int depthOdd = depth + ((depth + 1) % 2);  // rounded up to odd

	// every adder reads three bits from the front and appends its sum
	// at the back, so the last entry ends up as the slice sum
	logic [3*numFa:0] fifo;

	assign fifo[depth-1:0] = A;

	if (depthOdd > depth) begin : padZero
		assign fifo[depthOdd-1] = 1'b0;  // pad to odd count
	end

	if (speed == 0) begin : linearArr
		// head of the chain takes three input bits
		FullAdder faHead (
			.A (fifo[0]),
			.B (fifo[1]),
			.CI(fifo[2]),
			.S (fifo[depthOdd]),
			.CO(CO[0])
		);

		// each further adder folds two inputs into the running sum
		for (genvar i = 1; i < numFa; i++) begin : chain
			FullAdder faLink (
				.A (fifo[2*i+1]),
				.B (fifo[2*i+2]),
				.CI(fifo[depthOdd+i-1]),  // previous sum
				.S (fifo[depthOdd+i]),
				.CO(CO[i])
			);
		end
	end else begin : treeArr
		// adders consume the vector in groups of three, sums included,
		// which gives a log depth reduction
		for (genvar i = 0; i < numFa; i++) begin : tree
			FullAdder faNode (
				.A (fifo[3*i]),
				.B (fifo[3*i+1]),
				.CI(fifo[3*i+2]),
				.S (fifo[depthOdd+i]),
				.CO(CO[i])
			);
		end
	end

	assign S = fifo[3*numFa];  // last sum written

endmodule

//--- Cnt.sv
module Cnt #(
	parameter int depth = 18,  // bits to count, at least two
	parameter int speed = 1    // passed on to the slices
) (
	input  logic [depth-1:0]                  A,  // bits to count
	output logic [popPkg::log2floor(depth):0] S   // binary count of ones
);

	import popPkg::*;

	localparam int m = depth;                  // bits at level zero
	localparam int n = log2floor(depth) + 1;   // sum bits
	localparam int w = (m < 3) ? 3 : m;        // room for the padded top level

	// carry level i holds m >> i bits, all of weight 2**i
	logic [w-1:0] carry [n-1];

	if (depth < 2) begin : badDepth
		$error("Cnt needs depth of at least two");
	end

	assign carry[0][m-1:0] = A;

	// slice i reduces level i to sum bit i and the carries of level i+1
	for (genvar i = 0; i < n-2; i++) begin : levels
		CntSlice #(
			.depth(m >> i),
			.speed(speed)
		) slice (
			.A (carry[i][(m >> i)-1:0]),
			.S (S[i]),
			.CO(carry[i+1][(m >> (i+1))-1:0])
		);
	end

	// top level has two or three carries left
	if ((m >> (n-2)) == 2) begin : evenTop
		assign carry[n-2][2] = 1'b0;
	end

	// last adder gives the two most significant sum bits
	FullAdder faTop (
		.A (carry[n-2][0]),
		.B (carry[n-2][1]),
		.CI(carry[n-2][2]),
		.S (S[n-2]),
		.CO(S[n-1])
	);

endmodule

//--- operandPrep.sv
module operandPrep (
	input  logic                          clk,
	input  logic                          rstN,
	input  logic                          inValid,  // beat strobe
	input  logic [popPkg::wordWidth-1:0]  opA,
	input  logic [popPkg::wordWidth-1:0]  opB,
	input  popPkg::opMode_e               opMode,
	input  logic                          opLast,   // run ends with this beat
	input  logic [popPkg::tagWidth-1:0]   opTag,
	bitVecIf.src                          vecOut
);

	import popPkg::*;

	logic [wordWidth-1:0] selVec;  // vector picked by mode

	always_comb begin
		case (opMode)
			modeHam: selVec = opA ^ opB;  // differing bits
			modeAnd: selVec = opA & opB;  // shared ones
			default: selVec = opA;        // plain popcount
		endcase
	end

	// beat strobe
	always_ff @(posedge clk) begin
		if (!rstN) begin
			vecOut.valid <= 1'b0;
		end else begin
			vecOut.valid <= inValid;
		end
	end

	// vector with its attributes, held between beats
	always_ff @(posedge clk) begin
		if (inValid) begin
			vecOut.vector <= selVec;
			vecOut.last   <= opLast;
			vecOut.tag    <= opTag;
		end
	end

	// 2'b11 has no meaning
	modeKnown: assert property (@(posedge clk) disable iff (!rstN)
		inValid |-> opMode inside {modePop, modeHam, modeAnd})
		else $error("operandPrep: undefined opMode on a valid beat");

endmodule

//--- bitCounter.sv
module bitCounter (
	input  logic clk,
	input  logic rstN,
	bitVecIf.dst vecIn,   // selected vector
	countIf.src  cntOut   // its count, one cycle later
);

	import popPkg::*;

	beatCount_t vecCount;  // combinational count of vecIn.vector

	Cnt #(
		.depth(wordWidth),
		.speed(cntSpeed)
	) Cnt_inst (
		.A(vecIn.vector),
		.S(vecCount)
	);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			cntOut.valid <= 1'b0;
		end else begin
			cntOut.valid <= vecIn.valid;
		end
	end

	// count, last and tag move together
	always_ff @(posedge clk) begin
		if (vecIn.valid) begin
			cntOut.count <= vecCount;
			cntOut.last  <= vecIn.last;
			cntOut.tag   <= vecIn.tag;
		end
	end

	// adder tree against a direct popcount of the sampled vector
	countMatches: assert property (@(posedge clk) disable iff (!rstN)
		vecIn.valid |=> (cntOut.count <= wordWidth) &&
			(cntOut.count == $countones($past(vecIn.vector))))
		else $error("bitCounter: count disagrees with popcount of the vector");

endmodule

//--- runAccumulator.sv
module runAccumulator (
	input  logic                        clk,
	input  logic                        rstN,
	countIf.dst                         cntIn,     // per-beat counts
	output logic                        resValid,  // one cycle per run
	output popPkg::accCount_t           resCount,  // saturated run total
	output logic [popPkg::tagWidth-1:0] resTag     // tag of the last beat
);

	import popPkg::*;

	accCount_t         runSum;   // total of the open run so far
	accCount_t         nextSum;  // runSum plus this beat, clipped
	logic [accWidth:0] wideSum;  // extra msb flags overflow
	logic              endBeat;  // valid beat closing the run

	assign endBeat = cntIn.valid && cntIn.last;

	assign wideSum = {1'b0, runSum} + {{(accWidth + 1 - cntWidth){1'b0}}, cntIn.count};

	// stick at all ones once the total overflows
	assign nextSum = wideSum[accWidth] ? '1 : wideSum[accWidth-1:0];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			runSum   <= '0;
			resValid <= 1'b0;
		end else begin
			resValid <= endBeat;
			if (cntIn.valid) begin
				// a closing beat leaves the sum clear for the next run
				runSum <= cntIn.last ? '0 : nextSum;
			end
		end
	end

	// total includes the closing beat
	always_ff @(posedge clk) begin
		if (endBeat) begin
			resCount <= nextSum;
			resTag   <= cntIn.tag;
		end
	end

	// inside a run the sum only grows, a wrap would show up as a drop
	sumNoWrap: assert property (@(posedge clk) disable iff (!rstN)
		(cntIn.valid && !cntIn.last) |=> (runSum >= $past(runSum)))
		else $error("runAccumulator: running sum dropped inside a run");

endmodule

//--- hammingTop.sv
module hammingTop (
	input  logic                         clk,
	input  logic                         rstN,
	// operand beats
	input  logic                         inValid,
	input  logic [popPkg::wordWidth-1:0] opA,
	input  logic [popPkg::wordWidth-1:0] opB,
	input  popPkg::opMode_e              opMode,
	input  logic                         opLast,
	input  logic [popPkg::tagWidth-1:0]  opTag,
	// run totals, three cycles after the closing beat
	output logic                         resValid,
	output popPkg::accCount_t            resCount,
	output logic [popPkg::tagWidth-1:0]  resTag
);

	bitVecIf vecBus ();  // stage 1 to stage 2
	countIf  cntBus ();  // stage 2 to stage 3

	// stage 1, mode select
	operandPrep operandPrep_inst (
		.clk    (clk),
		.rstN   (rstN),
		.inValid(inValid),
		.opA    (opA),
		.opB    (opB),
		.opMode (opMode),
		.opLast (opLast),
		.opTag  (opTag),
		.vecOut (vecBus.src)
	);

	// stage 2, counter tree
	bitCounter bitCounter_inst (
		.clk   (clk),
		.rstN  (rstN),
		.vecIn (vecBus.dst),
		.cntOut(cntBus.src)
	);

	// stage 3, run sum
	runAccumulator runAccumulator_inst (
		.clk     (clk),
		.rstN    (rstN),
		.cntIn   (cntBus.dst),
		.resValid(resValid),
		.resCount(resCount),
		.resTag  (resTag)
	);

endmodule

//--- hammingTb.sv
module hammingTb;

	import popPkg::*;

	localparam int accMax = (1 << accWidth) - 1;  // saturated total

	// test lengths, used for the cycle budget
	localparam int resetCycles = 3;
	localparam int quietCycles = 10;   // no closing beat yet
	localparam int singleKinds = 6;    // zeros, ones, ones vs zeros, three random
	localparam int singleGap   = 4;    // idle cycles after each single beat
	localparam int numRuns     = 40;
	localparam int maxRunLen   = 8;
	localparam int maxIdleIn   = 2;    // idle cycles between beats of a run
	localparam int satBeats    = 2100;
	localparam int restartLen  = 3;    // run right after saturation
	localparam int drainCycles = 10;

	localparam int singleCycles = 3 * singleKinds * (1 + singleGap);
	localparam int multiCycles  = numRuns * (maxRunLen * (1 + maxIdleIn) + 1);
	localparam int cycleLimit   = resetCycles + quietCycles + singleCycles + multiCycles
		+ satBeats + restartLen + drainCycles + 50;

	logic                 clk = 1'b0;
	logic                 rstN;
	logic                 inValid;
	logic [wordWidth-1:0] opA;
	logic [wordWidth-1:0] opB;
	opMode_e              opMode;
	logic                 opLast;
	logic [tagWidth-1:0]  opTag;
	logic                 resValid;
	accCount_t            resCount;
	logic [tagWidth-1:0]  resTag;

	integer seed;                   // $random state
	int     cycles = 0;             // rising edges seen
	int     runTotal;               // expected sum of the open run

	accCount_t           expCount[$];  // one entry per closed run
	logic [tagWidth-1:0] expTag[$];
	int                  expCycle[$];  // edge at which resValid must be high

	hammingTop hammingTop_inst (
		.clk     (clk),
		.rstN    (rstN),
		.inValid (inValid),
		.opA     (opA),
		.opB     (opB),
		.opMode  (opMode),
		.opLast  (opLast),
		.opTag   (opTag),
		.resValid(resValid),
		.resCount(resCount),
		.resTag  (resTag)
	);

	always #5 clk = ~clk;  // period 10

	task automatic abortRun();
		$display("test failed");
		$fatal(1);
	endtask

	// ones in the vector picked by the mode
	function automatic beatCount_t refCount(input logic [wordWidth-1:0] a,
			input logic [wordWidth-1:0] b, input opMode_e mode);
		logic [wordWidth-1:0] vec;
		int n;
		case (mode)
			modeHam: vec = a ^ b;
			modeAnd: vec = a & b;
			default: vec = a;
		endcase
		n = 0;
		for (int i = 0; i < wordWidth; i++) begin
			if (vec[i])
				n++;
		end
		return beatCount_t'(n);
	endfunction

	task automatic checkCount(input accCount_t got, input accCount_t exp);
		if (got !== exp) begin
			$display("** Error at time %0t: run total %0d, expected %0d", $time, got, exp);
			abortRun();
		end
	endtask

	task automatic checkTag(input logic [tagWidth-1:0] got, input logic [tagWidth-1:0] exp);
		if (got !== exp) begin
			$display("** Error at time %0t: result tag %0h, expected %0h", $time, got, exp);
			abortRun();
		end
	endtask

	// one beat, sampled at the next rising edge
	task automatic driveBeat(input logic [wordWidth-1:0] a, input logic [wordWidth-1:0] b,
			input opMode_e mode, input logic last, input logic [tagWidth-1:0] tag);
		@(posedge clk);
		#1;
		inValid = 1'b1;
		opA     = a;
		opB     = b;
		opMode  = mode;
		opLast  = last;
		opTag   = tag;
		runTotal = runTotal + refCount(a, b, mode);
		if (runTotal > accMax)
			runTotal = accMax;  // clip like the hardware
		if (last) begin
			expCount.push_back(accCount_t'(runTotal));
			expTag.push_back(tag);
			expCycle.push_back(cycles + 3);  // three edges later
			runTotal = 0;
		end
	endtask

	// junk on the data lines, ignored while inValid is low
	task automatic driveIdle(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
			inValid = 1'b0;
			opA     = $random(seed);
			opB     = $random(seed);
			opLast  = $random(seed);  // even a stray last must do nothing
			opTag   = $random(seed);
		end
	endtask

	// edge count and timeout
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("timeout: run still going after %0d cycles", cycles);
			abortRun();
		end
	end

	// compare at the falling edge, outputs settled
	always @(negedge clk) begin
		if (rstN === 1'b1) begin
			if (resValid === 1'b1) begin
				if (expCount.size() == 0) begin
					$display("result strobe at time %0t with no closed run pending", $time);
					abortRun();
				end
				if (expCycle[0] != cycles) begin
					$display("result at cycle %0d, the run closed for cycle %0d",
						cycles, expCycle[0]);
					abortRun();
				end
				checkCount(resCount, expCount.pop_front());
				checkTag(resTag, expTag.pop_front());
				void'(expCycle.pop_front());
			end else if (resValid !== 1'b0) begin
				$display("result strobe is unknown at time %0t", $time);
				abortRun();
			end else if (expCycle.size() != 0 && expCycle[0] <= cycles) begin
				$display("no result at cycle %0d for a closed run", expCycle[0]);
				abortRun();
			end
		end
	end

	initial begin
		logic [wordWidth-1:0] a;
		logic [wordWidth-1:0] b;
		int runLen;
		seed     = 32'h55b980ac;
		runTotal = 0;
		rstN     = 1'b0;
		inValid  = 1'b0;
		opA      = '0;
		opB      = '0;
		opMode   = modePop;
		opLast   = 1'b0;
		opTag    = '0;

		repeat (resetCycles) @(posedge clk);
		#1;
		rstN = 1'b1;

		// nothing closed, so no result may show up
		driveIdle(quietCycles);

		// one beat per run, every mode and the corner operands
		for (int m = 0; m < 3; m++) begin
			for (int k = 0; k < singleKinds; k++) begin
				case (k)
					0: begin
						a = '0;
						b = '0;
					end
					1: begin
						a = '1;
						b = '1;
					end
					2: begin
						a = '1;
						b = '0;
					end
					default: begin
						a = $random(seed);
						b = $random(seed);
					end
				endcase
				driveBeat(a, b, opMode_e'(m), 1'b1, $random(seed));
				driveIdle(singleGap);
			end
		end

		// longer runs, mixed modes, gaps inside, often back to back
		for (int r = 0; r < numRuns; r++) begin
			runLen = 1 + ($unsigned($random(seed)) % maxRunLen);
			for (int j = 0; j < runLen; j++) begin
				driveBeat($random(seed), $random(seed), opMode_e'($unsigned($random(seed)) % 3),
					j == runLen - 1, $random(seed));
				if (j < runLen - 1)
					driveIdle($unsigned($random(seed)) % (maxIdleIn + 1));
			end
			if ($random(seed) & 1)
				driveIdle(1);
		end

		// 2100 x 32 overflows 16 bits
		for (int i = 0; i < satBeats; i++) begin
			driveBeat('1, $random(seed), modePop, i == satBeats - 1, $random(seed));
		end

		// sum must restart from zero
		for (int i = 0; i < restartLen; i++) begin
			driveBeat($random(seed), $random(seed), opMode_e'($unsigned($random(seed)) % 3),
				i == restartLen - 1, $random(seed));
		end

		driveIdle(drainCycles);

		if (expCount.size() != 0) begin
			$display("%0d run totals never came out", expCount.size());
			abortRun();
		end else begin
			$display("test passed");
			$finish;
		end
	end

endmodule

//--- verilog.f
popPkg.sv
popIfs.sv
FullAdder.sv
CntSlice.sv
Cnt.sv
operandPrep.sv
bitCounter.sv
runAccumulator.sv
hammingTop.sv
hammingTb.sv

//--- Bender.yml
package:
  name: hammingUnit

sources:
  - popPkg.sv
  - popIfs.sv
  - FullAdder.sv
  - CntSlice.sv
  - Cnt.sv
  - operandPrep.sv
  - bitCounter.sv
  - runAccumulator.sv
  - hammingTop.sv
  - target: test
    files:
      - hammingTb.sv
